// File: src.f
rtl/cpu_isa_pkg.sv
rtl/cpu_pipe_pkg.sv
rtl/cpu_decode.sv
rtl/cpu_execute.sv
rtl/cpu_result.sv
rtl/cpu_top.sv
tests/cpu_checker.sv
tests/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu_pipe

sources:
  - files:
      - rtl/cpu_isa_pkg.sv
      - rtl/cpu_pipe_pkg.sv
      - rtl/cpu_decode.sv
      - rtl/cpu_execute.sv
      - rtl/cpu_result.sv
      - rtl/cpu_top.sv
  - target: test
    files:
      - tests/cpu_checker.sv
      - tests/cpu_tb.sv

// File: tests/cpu_tb.sv
module cpu_tb;
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    localparam int n_inst_lp          = 400;
    localparam int tail_lp            = 8;
    localparam int reset_cycles_lp    = 8;
    localparam int watchdog_cycles_lp = (n_inst_lp + tail_lp) * 4 + reset_cycles_lp;

    typedef struct packed {
        int          due;
        logic [15:0] inst;
        retire_t     rec;
    } ret_item_t;

    typedef struct packed {
        int          due;
        logic [15:0] inst;
        flags_t      flags;
    } flag_item_t;

    logic        clk_i;
    logic        reset_i;
    logic        inst_valid_i;
    logic [15:0] inst_i;
    retire_t     retire_o;
    flags_t      flags_o;
    logic        hlt_o;

    logic [31:0]  lcg_state = 32'hfaa8_b466;
    int           cyc = 0;
    int           hlt_due = 32'h7fff_ffff;
    logic [15:0]  m_regs [16];
    logic [15:0]  m_mem [16];
    flags_t       m_flags;
    logic         m_halted;
    ret_item_t    ret_q [$];
    flag_item_t   flag_q [$];

    cpu_top UUT (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .retire_o     (retire_o),
        .flags_o      (flags_o),
        .hlt_o        (hlt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Rising-edge count that times the expected results
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    function automatic logic [15:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic compare_retire(input string name, input retire_t exp, input retire_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_flags(input string name, input flags_t exp, input flags_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic compare_halt(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Register indices stay in r0..r3 so that dependences are frequent
    function automatic logic [15:0] gen_inst();
        logic [15:0] r;
        logic [15:0] s;
        logic [3:0]  op;
        logic [15:0] inst;
        r    = rand_next();
        s    = rand_next();
        op   = 4'(r[15:8] % 15);
        inst = {op, 2'b00, r[1:0], 2'b00, r[3:2], s[3:0]};
        if (op <= 4'h4) begin
            inst[3:0] = {2'b00, s[5:4]};
        end
        if (op == OP_LLB || op == OP_LHB) begin
            inst[7:0] = s[15:8];
        end
        return inst;
    endfunction

    // In-order ISA model that queues what the DUT must show two cycles later
    task automatic model_step(input logic [15:0] inst);
        opcode_e     op;
        logic [3:0]  rd;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [15:0] addr;
        logic [3:0]  sh;
        int          wide;
        logic        writes;
        op     = opcode_e'(inst[15:12]);
        rd     = inst[11:8];
        a      = m_regs[inst[7:4]];
        b      = m_regs[inst[3:0]];
        sh     = inst[3:0];
        addr   = a + {{12{inst[3]}}, inst[3:0]};
        res    = '0;
        wide   = 0;
        writes = 1'b0;
        if (!m_halted) begin
            case (op)
                OP_ADD: wide = $signed(a) + $signed(b);
                OP_SUB: wide = $signed(a) - $signed(b);
                default: wide = 0;
            endcase
            case (op)
                OP_ADD, OP_SUB: res = wide[15:0];
                OP_XOR: res = a ^ b;
                OP_AND: res = a & b;
                OP_OR:  res = a | b;
                OP_SLL: res = a << sh;
                OP_SRA: begin
                    res = a;
                    repeat (sh) res = {res[15], res[15:1]};
                end
                OP_ROR: res = (sh == 0) ? a : ((a >> sh) | (a << (16 - sh)));
                OP_LW:  res = m_mem[addr[3:0]];
                OP_SW:  m_mem[addr[3:0]] = m_regs[rd];
                OP_LLB: res = {m_regs[rd][15:8], inst[7:0]};
                OP_LHB: res = {inst[7:0], m_regs[rd][7:0]};
                OP_HLT: begin
                    m_halted = 1'b1;
                    hlt_due  = cyc + 3;
                end
                default: res = '0;
            endcase
            writes = op inside {OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR, OP_SLL, OP_SRA,
                                OP_ROR, OP_LW, OP_LLB, OP_LHB};
            if (op inside {OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR, OP_SLL, OP_SRA, OP_ROR}) begin
                m_flags.z = (res == 16'h0000);
                m_flags.n = res[15];
            end
            if (op inside {OP_ADD, OP_SUB}) begin
                m_flags.v = (wide > 32767) || (wide < -32768);
            end
            if (writes) begin
                m_regs[rd] = res;
                ret_q.push_back('{due: cyc + 2, inst: inst,
                                  rec: '{valid: 1'b1, rd: rd, data: res}});
            end
        end
        flag_q.push_back('{due: cyc + 2, inst: inst, flags: m_flags});
    endtask

    task automatic drive_cycle(input logic valid, input logic [15:0] inst);
        @(posedge clk_i);
        #2;
        inst_valid_i = valid;
        inst_i       = inst;
        if (valid) begin
            model_step(inst);
        end
    endtask

    // Outputs are sampled mid-cycle where they are stable
    always @(negedge clk_i) begin : monitor
        ret_item_t  r;
        flag_item_t f;
        if (UUT.u_result.u_checker.fail_count != 0) begin
            stop_with_failure("An assertion on the result stage failed");
        end
        if (!reset_i) begin
            if (retire_o.valid === 1'b1) begin
                if (ret_q.size() == 0) begin
                    stop_with_failure(
                        "Retire seen with no register-writing instruction in flight");
                end else begin
                    r = ret_q.pop_front();
                    if (r.due != cyc) begin
                        stop_with_failure($sformatf("Retire at cycle %0d was due at cycle %0d",
                                                    cyc, r.due));
                    end else begin
                        compare_retire($sformatf("retire_o for %h", r.inst), r.rec, retire_o);
                    end
                end
            end else if (ret_q.size() != 0 && ret_q[0].due <= cyc) begin
                stop_with_failure($sformatf("Expected retire for %h did not appear",
                                            ret_q[0].inst));
            end
            while (flag_q.size() != 0 && flag_q[0].due == cyc) begin
                f = flag_q.pop_front();
                compare_flags($sformatf("flags_o after %h", f.inst), f.flags, flags_o);
            end
            compare_halt("hlt_o", cyc >= hlt_due, hlt_o);
        end
    end

    initial begin
        repeat (watchdog_cycles_lp) @(posedge clk_i);
        stop_with_failure("Watchdog expired before the instruction stream finished");
    end

    initial begin : stimulus
        logic [15:0] gap;
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        m_flags      = '0;
        m_halted     = 1'b0;
        for (int i = 0; i < 16; i++) begin
            m_regs[i] = '0;
            m_mem[i]  = '0;
        end
        repeat (reset_cycles_lp) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        @(negedge clk_i);
        compare_flags("flags_o after reset", '0, flags_o);

        // Random gaps leave some dependent pairs adjacent and some one apart
        for (int i = 0; i < n_inst_lp; i++) begin
            gap = rand_next();
            if (gap[1:0] == 2'b00) begin
                drive_cycle(1'b0, gap);
            end
            drive_cycle(1'b1, gen_inst());
        end
        drive_cycle(1'b1, 16'hf000);
        // Strobes after HLT must be ignored
        repeat (tail_lp) drive_cycle(1'b1, gen_inst());
        drive_cycle(1'b0, 16'h0000);
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);

        if (ret_q.size() != 0 || flag_q.size() != 0) begin
            stop_with_failure("Expected results were still pending at the end of the run");
        end else if (UUT.u_result.u_checker.fail_count != 0) begin
            stop_with_failure("An assertion on the result stage failed");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// File: tests/cpu_checker.sv
module cpu_checker (
    input logic                  clk_i,
    input logic                  reset_i,
    input cpu_pipe_pkg::retire_t retire_i,
    input logic                  hlt_i
);

    int unsigned fail_count = 0;

    // Halt is sticky until reset
    hlt_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
        hlt_i |=> hlt_i)
        else begin
            fail_count++;
            $error("hlt_o fell without a reset");
        end

    // Nothing is in flight behind a HLT
    no_retire_halted: assert property (@(posedge clk_i) disable iff (reset_i)
        hlt_i |-> !retire_i.valid)
        else begin
            fail_count++;
            $error("Retire valid while halted");
        end

    retire_valid_known: assert property (@(posedge clk_i) disable iff (reset_i)
        !$isunknown(retire_i.valid))
        else begin
            fail_count++;
            $error("Retire valid bit is unknown");
        end

    retire_fields_known: assert property (@(posedge clk_i) disable iff (reset_i)
        retire_i.valid |-> !$isunknown(retire_i))
        else begin
            fail_count++;
            $error("Retire fields unknown while valid");
        end

endmodule

bind cpu_result cpu_checker u_checker (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .retire_i (retire_o),
    .hlt_i    (hlt_o)
);

// File: rtl/cpu_top.sv
module cpu_top (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  inst_valid_i,
    input  logic [15:0]           inst_i,
    output cpu_pipe_pkg::retire_t retire_o,
    output cpu_isa_pkg::flags_t   flags_o,
    output logic                  hlt_o
);
    import cpu_pipe_pkg::*;

    decoded_t dec;
    exec_t    exe;
    retire_t  wb;

    cpu_decode u_decode (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_i         (wb),
        .dec_o        (dec)
    );

    cpu_execute u_execute (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .dec_i   (dec),
        .fwd_i   (wb),
        .exe_o   (exe),
        .flags_o (flags_o)
    );

    // Write-back feeds the register file and forwarding
    cpu_result u_result (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .exe_i    (exe),
        .retire_o (wb),
        .hlt_o    (hlt_o)
    );

    assign retire_o = wb;

endmodule

// File: rtl/cpu_result.sv
module cpu_result (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  cpu_pipe_pkg::exec_t   exe_i,
    output cpu_pipe_pkg::retire_t retire_o,
    output logic                  hlt_o
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [data_width_lp-1:0]      dmem_q [dmem_depth_lp];
    logic [dmem_addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0]      load_data;
    logic                          hlt_q;

    // Only the low address bits select a word
    assign addr      = exe_i.alu_result[dmem_addr_width_lp-1:0];
    assign load_data = dmem_q[addr];

    // Data memory, asynchronous read
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dmem_q <= '{default: '0};
        end else if (exe_i.valid && exe_i.mem_write) begin
            dmem_q[addr] <= exe_i.store_data;
        end
    end

    // Write-back select
    always_comb begin
        retire_o.valid = exe_i.valid & exe_i.reg_write;
        retire_o.rd    = exe_i.rd;
        retire_o.data  = exe_i.mem_read ? load_data : exe_i.alu_result;
    end

    // Sticky until reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hlt_q <= 1'b0;
        end else if (exe_i.valid && exe_i.halt) begin
            hlt_q <= 1'b1;
        end
    end

    assign hlt_o = hlt_q;

endmodule

// File: rtl/cpu_execute.sv
module cpu_execute (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  cpu_pipe_pkg::decoded_t dec_i,
    input  cpu_pipe_pkg::retire_t  fwd_i,
    output cpu_pipe_pkg::exec_t    exe_o,
    output cpu_isa_pkg::flags_t    flags_o
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [data_width_lp-1:0]   opa;
    logic [data_width_lp-1:0]   opb;
    logic [data_width_lp-1:0]   sum;
    logic [data_width_lp-1:0]   diff;
    logic [2*data_width_lp-1:0] rot;
    logic [imm4_width_lp-1:0]   shamt;
    logic [data_width_lp-1:0]   result;
    logic                       ovf_add;
    logic                       ovf_sub;
    flags_t                     flags_n;
    flags_t                     flags_q;
    exec_t                      exe_n;
    exec_t                      exe_q;

    // The instruction one ahead sits in the result stage
    assign opa = (fwd_i.valid && fwd_i.rd == dec_i.rs) ? fwd_i.data : dec_i.opa;
    assign opb = (fwd_i.valid && fwd_i.rd == dec_i.rt) ? fwd_i.data : dec_i.opb;

    assign shamt = dec_i.imm4[imm4_width_lp-1:0];
    assign sum   = opa + opb;
    assign diff  = opa - opb;
    assign rot   = {opa, opa} >> shamt;

    // Signed overflow of the wrapping add and subtract
    assign ovf_add = (opa[data_width_lp-1] == opb[data_width_lp-1]) &&
                     (sum[data_width_lp-1] != opa[data_width_lp-1]);
    assign ovf_sub = (opa[data_width_lp-1] != opb[data_width_lp-1]) &&
                     (diff[data_width_lp-1] != opa[data_width_lp-1]);

    always_comb begin
        case (dec_i.op)
            OP_ADD: result = sum;
            OP_SUB: result = diff;
            OP_XOR: result = opa ^ opb;
            OP_AND: result = opa & opb;
            OP_OR:  result = opa | opb;
            OP_SLL: result = opa << shamt;
            OP_SRA: result = $signed(opa) >>> shamt;
            OP_ROR: result = rot[data_width_lp-1:0];
            // Memory address
            OP_LW, OP_SW: result = opa + dec_i.imm4;
            OP_LLB: result = {opa[data_width_lp-1:imm8_width_lp], dec_i.imm8[imm8_width_lp-1:0]};
            OP_LHB: result = {dec_i.imm8[imm8_width_lp-1:0], opa[imm8_width_lp-1:0]};
            default: result = '0;
        endcase
    end

    // Flag rule per opcode
    always_comb begin
        flags_n = flags_q;
        if (dec_i.valid) begin
            case (dec_i.op)
                OP_ADD, OP_SUB: begin
                    flags_n.z = (result == '0);
                    flags_n.n = result[data_width_lp-1];
                    flags_n.v = (dec_i.op == OP_ADD) ? ovf_add : ovf_sub;
                end
                OP_XOR, OP_AND, OP_OR, OP_SLL, OP_SRA, OP_ROR: begin
                    flags_n.z = (result == '0);
                    flags_n.n = result[data_width_lp-1];
                end
                default: begin
                    flags_n = flags_q;
                end
            endcase
        end
    end

    always_comb begin
        exe_n.valid      = dec_i.valid;
        exe_n.rd         = dec_i.rd;
        exe_n.alu_result = result;
        exe_n.store_data = opb;
        exe_n.reg_write  = dec_i.reg_write;
        exe_n.mem_read   = dec_i.mem_read;
        exe_n.mem_write  = dec_i.mem_write;
        exe_n.halt       = dec_i.halt;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exe_q.valid <= 1'b0;
            flags_q     <= '0;
        end else begin
            exe_q   <= exe_n;
            flags_q <= flags_n;
        end
    end

    assign exe_o   = exe_q;
    assign flags_o = flags_q;

endmodule

// File: rtl/cpu_decode.sv
module cpu_decode (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   inst_valid_i,
    input  logic [15:0]            inst_i,
    input  cpu_pipe_pkg::retire_t  wb_i,
    output cpu_pipe_pkg::decoded_t dec_o
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [data_width_lp-1:0]    regs_q [reg_count_lp];
    logic                        halted_q;
    logic                        capture;
    opcode_e                     op;
    logic [reg_idx_width_lp-1:0] rd;
    logic [reg_idx_width_lp-1:0] rs;
    logic [reg_idx_width_lp-1:0] rt;
    logic [imm4_width_lp-1:0]    imm4;
    logic [imm8_width_lp-1:0]    imm8;
    logic [reg_idx_width_lp-1:0] src_a_idx;
    logic [reg_idx_width_lp-1:0] src_b_idx;
    logic [data_width_lp-1:0]    rdata_a;
    logic [data_width_lp-1:0]    rdata_b;
    decoded_t                    dec_n;
    decoded_t                    dec_q;

    // Strobes are dropped once a HLT has been taken
    assign capture = inst_valid_i & ~halted_q;

    // Field split
    assign op   = opcode_e'(inst_i[op_lsb_lp +: op_width_lp]);
    assign rd   = inst_i[rd_lsb_lp +: reg_idx_width_lp];
    assign rs   = inst_i[rs_lsb_lp +: reg_idx_width_lp];
    assign rt   = inst_i[rt_lsb_lp +: reg_idx_width_lp];
    assign imm4 = inst_i[imm4_width_lp-1:0];
    assign imm8 = inst_i[imm8_width_lp-1:0];

    // Byte loads merge into the old rd, stores write the value of rd
    assign src_a_idx = (op == OP_LLB || op == OP_LHB) ? rd : rs;
    assign src_b_idx = (op == OP_SW) ? rd : rt;

    // Register reads with write-through of a same-cycle write-back
    assign rdata_a = (wb_i.valid && wb_i.rd == src_a_idx) ? wb_i.data : regs_q[src_a_idx];
    assign rdata_b = (wb_i.valid && wb_i.rd == src_b_idx) ? wb_i.data : regs_q[src_b_idx];

    always_comb begin
        dec_n           = '0;
        dec_n.valid     = capture;
        dec_n.op        = op;
        dec_n.rd        = rd;
        dec_n.rs        = src_a_idx;
        dec_n.rt        = src_b_idx;
        dec_n.opa       = rdata_a;
        dec_n.opb       = rdata_b;
        dec_n.imm4      = {{(data_width_lp - imm4_width_lp){imm4[imm4_width_lp-1]}}, imm4};
        dec_n.imm8      = {{(data_width_lp - imm8_width_lp){imm8[imm8_width_lp-1]}}, imm8};
        case (op)
            OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR,
            OP_SLL, OP_SRA, OP_ROR, OP_LLB, OP_LHB: begin
                dec_n.reg_write = 1'b1;
            end
            OP_LW: begin
                dec_n.reg_write = 1'b1;
                dec_n.mem_read  = 1'b1;
            end
            OP_SW: begin
                dec_n.mem_write = 1'b1;
            end
            OP_HLT: begin
                dec_n.halt = 1'b1;
            end
            // Unlisted codes pass through as NOP
            default: begin
                dec_n.reg_write = 1'b0;
            end
        endcase
    end

    // Register file
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            regs_q <= '{default: '0};
        end else if (wb_i.valid) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            halted_q    <= 1'b0;
            dec_q.valid <= 1'b0;
        end else begin
            dec_q <= dec_n;
            if (capture && op == OP_HLT) begin
                halted_q <= 1'b1;
            end
        end
    end

    assign dec_o = dec_q;

endmodule

// File: rtl/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    // Decode to execute
    // rs and rt name the registers behind opa and opb, which for
    // LLB/LHB and SW may be the rd field of the instruction
    typedef struct packed {
        logic                                         valid;
        cpu_isa_pkg::opcode_e                         op;
        logic [cpu_isa_pkg::reg_idx_width_lp-1:0]     rd;
        logic [cpu_isa_pkg::reg_idx_width_lp-1:0]     rs;
        logic [cpu_isa_pkg::reg_idx_width_lp-1:0]     rt;
        logic [cpu_isa_pkg::data_width_lp-1:0]        opa;
        logic [cpu_isa_pkg::data_width_lp-1:0]        opb;
        logic [cpu_isa_pkg::data_width_lp-1:0]        imm4;
        logic [cpu_isa_pkg::data_width_lp-1:0]        imm8;
        logic                                         reg_write;
        logic                                         mem_read;
        logic                                         mem_write;
        logic                                         halt;
    } decoded_t;

    // Execute to result
    typedef struct packed {
        logic                                         valid;
        logic [cpu_isa_pkg::reg_idx_width_lp-1:0]     rd;
        logic [cpu_isa_pkg::data_width_lp-1:0]        alu_result;
        logic [cpu_isa_pkg::data_width_lp-1:0]        store_data;
        logic                                         reg_write;
        logic                                         mem_read;
        logic                                         mem_write;
        logic                                         halt;
    } exec_t;

    // Register write-back record, also the forwarding source
    typedef struct packed {
        logic                                         valid;
        logic [cpu_isa_pkg::reg_idx_width_lp-1:0]     rd;
        logic [cpu_isa_pkg::data_width_lp-1:0]        data;
    } retire_t;

endpackage

// File: rtl/cpu_isa_pkg.sv
package cpu_isa_pkg;

    // Datapath and storage sizes
    localparam int unsigned data_width_lp      = 16;
    localparam int unsigned reg_count_lp       = 16;
    localparam int unsigned reg_idx_width_lp   = 4;
    localparam int unsigned dmem_depth_lp      = 16;
    localparam int unsigned dmem_addr_width_lp = $clog2(dmem_depth_lp);

    // Instruction field positions and widths
    localparam int unsigned op_width_lp   = 4;
    localparam int unsigned op_lsb_lp     = 12;
    localparam int unsigned rd_lsb_lp     = 8;
    localparam int unsigned rs_lsb_lp     = 4;
    localparam int unsigned rt_lsb_lp     = 0;
    localparam int unsigned imm4_width_lp = 4;
    localparam int unsigned imm8_width_lp = 8;

    // Opcodes, codes C..E are not listed and decode as NOP
    typedef enum logic [op_width_lp-1:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_XOR = 4'h2,
        OP_AND = 4'h3,
        OP_OR  = 4'h4,
        OP_SLL = 4'h5,
        OP_SRA = 4'h6,
        OP_ROR = 4'h7,
        OP_LW  = 4'h8,
        OP_SW  = 4'h9,
        OP_LLB = 4'ha,
        OP_LHB = 4'hb,
        OP_HLT = 4'hf
    } opcode_e;

    // Condition flags
    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } flags_t;

endpackage
